/* hw/chroni_pkg.sv */
package chroni_pkg;

   localparam int TEXT_COLS   = 16;
   localparam int GLYPH_ROWS  = 8;
   localparam int LINE_PIXELS = 128;

   typedef logic [11:0]                      vram_addr_t;
   typedef logic [7:0]                       byte_t;
   typedef logic [$clog2(TEXT_COLS)-1:0]     col_t;
   typedef logic [$clog2(LINE_PIXELS)-1:0]   pix_idx_t;
   typedef logic [3:0]                       color_t;
   typedef logic [$clog2(GLYPH_ROWS)-1:0]    glyph_row_t;

   // cpu_addr[15:7] of the register window
   localparam logic [8:0] REG_BASE     = 9'h120;
   localparam logic [6:0] REG_DL_LO    = 7'h00;
   localparam logic [6:0] REG_DL_HI    = 7'h01;
   localparam logic [6:0] REG_CHARSET  = 7'h02;
   localparam logic [6:0] REG_VADDR_LO = 7'h06;
   localparam logic [6:0] REG_VADDR_HI = 7'h07;
   localparam logic [6:0] REG_VDATA    = 7'h09;

   localparam logic [3:0] DL_BLANK = 4'h0;
   localparam logic [3:0] DL_TEXT  = 4'h1;
   localparam logic [3:0] DL_END   = 4'hf;

   typedef enum logic [1:0] {DL_IDLE, DL_READ, DL_WAIT, DL_HALT} dl_state_t;

   typedef enum logic [2:0] {FT_IDLE, FT_CHAR, FT_ATTR, FT_FONT, FT_SEND, FT_DRAIN} fetch_state_t;

endpackage

/* hw/chroni_ifs.sv */
`timescale 1ns/100ps

// line command from the display-list processor to the text fetcher
interface line_cmd_if;
   logic                   start;
   logic                   blank;
   chroni_pkg::vram_addr_t char_addr;
   chroni_pkg::vram_addr_t attr_addr;
   chroni_pkg::glyph_row_t glyph_row;
   chroni_pkg::byte_t      charset;
   logic                   busy;

   modport master (output start, blank, char_addr, attr_addr, glyph_row, charset,
                   input busy);
   modport slave  (input start, blank, char_addr, attr_addr, glyph_row, charset,
                   output busy);
endinterface

// one font byte plus its attribute, handed to the pixel expander
interface glyph_if;
   logic              valid;
   chroni_pkg::byte_t font;
   chroni_pkg::byte_t attr;
   chroni_pkg::col_t  col;
   logic              blank;
   logic              last;
   logic              busy;

   modport master (output valid, font, attr, col, blank, last, input busy);
   modport slave  (input valid, font, attr, col, blank, last, output busy);
endinterface

/* hw/cpu_regs.sv */
`timescale 1ns/100ps

module cpu_regs (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   input  logic [15:0]            cpu_addr,
   input  chroni_pkg::byte_t      cpu_wr_data,
   input  logic                   cpu_wr_en,
   output chroni_pkg::byte_t      cpu_rd_data,
   output chroni_pkg::vram_addr_t dl_base,
   output chroni_pkg::byte_t      charset,
   output logic                   vram_wr_en,
   output chroni_pkg::vram_addr_t vram_wr_addr,
   output chroni_pkg::byte_t      vram_wr_data
);

   logic                   wr_en_d;
   logic                   wr_rise;
   logic                   reg_cs;
   logic [6:0]             offset;
   chroni_pkg::vram_addr_t vram_addr;   // auto-incrementing data port address

   assign reg_cs  = (cpu_addr[15:7] == chroni_pkg::REG_BASE);
   assign offset  = cpu_addr[6:0];
   assign wr_rise = cpu_wr_en && !wr_en_d;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         wr_en_d    <= 1'b0;
         dl_base    <= '0;
         charset    <= '0;
         vram_addr  <= '0;
         vram_wr_en <= 1'b0;
      end else begin
         wr_en_d    <= cpu_wr_en;
         vram_wr_en <= 1'b0;
         if (reg_cs && wr_rise) begin
            case (offset)
               chroni_pkg::REG_DL_LO:    dl_base[7:0]    <= cpu_wr_data;
               chroni_pkg::REG_DL_HI:    dl_base[11:8]   <= cpu_wr_data[3:0];
               chroni_pkg::REG_CHARSET:  charset         <= cpu_wr_data;
               chroni_pkg::REG_VADDR_LO: vram_addr[7:0]  <= cpu_wr_data;
               chroni_pkg::REG_VADDR_HI: vram_addr[11:8] <= cpu_wr_data[3:0];
               chroni_pkg::REG_VDATA: begin
                  vram_wr_en   <= 1'b1;
                  vram_wr_addr <= vram_addr;
                  vram_wr_data <= cpu_wr_data;
                  vram_addr    <= vram_addr + 1'b1;   // wraps at 4k
               end
               default: ;
            endcase
         end
      end
   end

   // registered read-back
   always_ff @(posedge sys_clk) begin
      cpu_rd_data <= 8'h00;
      if (reg_cs) begin
         case (offset)
            chroni_pkg::REG_DL_LO:    cpu_rd_data <= dl_base[7:0];
            chroni_pkg::REG_DL_HI:    cpu_rd_data <= {4'h0, dl_base[11:8]};
            chroni_pkg::REG_CHARSET:  cpu_rd_data <= charset;
            chroni_pkg::REG_VADDR_LO: cpu_rd_data <= vram_addr[7:0];
            chroni_pkg::REG_VADDR_HI: cpu_rd_data <= {4'h0, vram_addr[11:8]};
            default: ;
         endcase
      end
   end

endmodule

/* hw/video_ram.sv */
`timescale 1ns/100ps

module video_ram (
   input  logic                   sys_clk,
   input  logic                   wr_en,
   input  chroni_pkg::vram_addr_t wr_addr,
   input  chroni_pkg::byte_t      wr_data,
   input  chroni_pkg::vram_addr_t dl_rd_addr,
   input  chroni_pkg::vram_addr_t fetch_rd_addr,
   output chroni_pkg::byte_t      dl_rd_data,
   output chroni_pkg::byte_t      fetch_rd_data
);

   chroni_pkg::byte_t mem [2**$bits(chroni_pkg::vram_addr_t)];

   always_ff @(posedge sys_clk) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
      // separate read ports for the decoder and the fetcher
      dl_rd_data    <= mem[dl_rd_addr];
      fetch_rd_data <= mem[fetch_rd_addr];
   end

endmodule

/* hw/dl_decode.sv */
`timescale 1ns/100ps

module dl_decode (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   input  logic                   frame_start,
   input  logic                   line_start,
   input  chroni_pkg::vram_addr_t dl_base,
   input  chroni_pkg::byte_t      charset,
   output chroni_pkg::vram_addr_t rd_addr,
   input  chroni_pkg::byte_t      rd_data,
   line_cmd_if.master             cmd
);

   chroni_pkg::dl_state_t  state;
   chroni_pkg::vram_addr_t ptr;
   logic [2:0]             byte_idx;
   logic [3:0]             mode;
   chroni_pkg::byte_t      lines_left;   // scanlines still to issue for this entry
   logic                   entry_done;

   assign rd_addr = ptr;

   // blank entries end after the count byte, text entries after six bytes
   assign entry_done = (byte_idx == 3'd5) ||
                       (byte_idx == 3'd1 && mode == chroni_pkg::DL_BLANK);

   always_ff @(posedge sys_clk) begin
      cmd.start <= 1'b0;
      if (!reset_n || frame_start) begin
         state      <= chroni_pkg::DL_IDLE;
         ptr        <= dl_base;
         lines_left <= '0;
      end else begin
         case (state)
            chroni_pkg::DL_IDLE: begin
               if (line_start && !cmd.busy) begin
                  if (lines_left == '0) begin
                     state    <= chroni_pkg::DL_READ;
                     byte_idx <= '0;
                  end else begin
                     // same entry again, no display-list read
                     lines_left    <= lines_left - 1'b1;
                     cmd.glyph_row <= cmd.glyph_row + 1'b1;
                     if (cmd.glyph_row ==
                         chroni_pkg::glyph_row_t'(chroni_pkg::GLYPH_ROWS - 1)) begin
                        cmd.char_addr <= cmd.char_addr +
                                         chroni_pkg::vram_addr_t'(chroni_pkg::TEXT_COLS);
                        cmd.attr_addr <= cmd.attr_addr +
                                         chroni_pkg::vram_addr_t'(chroni_pkg::TEXT_COLS);
                     end
                     cmd.charset <= charset;
                     cmd.start   <= 1'b1;
                  end
               end
            end
            chroni_pkg::DL_READ: state <= chroni_pkg::DL_WAIT;   // vram latches ptr
            chroni_pkg::DL_WAIT: begin
               ptr      <= ptr + 1'b1;
               byte_idx <= byte_idx + 1'b1;
               state    <= chroni_pkg::DL_READ;
               case (byte_idx)
                  3'd0: begin
                     mode <= rd_data[3:0];
                     if (rd_data[3:0] == chroni_pkg::DL_END)
                        state <= chroni_pkg::DL_HALT;
                  end
                  3'd1: lines_left <= rd_data - 1'b1;
                  3'd2: cmd.char_addr[7:0]  <= rd_data;
                  3'd3: cmd.char_addr[11:8] <= rd_data[3:0];
                  3'd4: cmd.attr_addr[7:0]  <= rd_data;
                  default: cmd.attr_addr[11:8] <= rd_data[3:0];
               endcase
               if (entry_done) begin
                  state         <= chroni_pkg::DL_IDLE;
                  cmd.blank     <= (mode != chroni_pkg::DL_TEXT);
                  cmd.glyph_row <= '0;
                  cmd.charset   <= charset;
                  cmd.start     <= 1'b1;
               end
            end
            default: ;   // halted until frame_start
         endcase
      end
   end

endmodule

/* hw/text_fetch.sv */
`timescale 1ns/100ps

module text_fetch (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   input  logic                   frame_start,
   output chroni_pkg::vram_addr_t rd_addr,
   input  chroni_pkg::byte_t      rd_data,
   line_cmd_if.slave              cmd,
   glyph_if.master                glyph
);

   chroni_pkg::fetch_state_t state;
   chroni_pkg::vram_addr_t   addr;
   chroni_pkg::vram_addr_t   font_addr;
   chroni_pkg::col_t         col;
   logic                     phase;   // high on the cycle the read data is valid
   logic                     ready;
   chroni_pkg::byte_t        char_buf [chroni_pkg::TEXT_COLS];
   chroni_pkg::byte_t        attr_buf [chroni_pkg::TEXT_COLS];

   // valid is checked as well since busy rises a cycle after the pulse
   assign ready     = !glyph.valid && !glyph.busy;
   assign font_addr = {cmd.charset[1:0], char_buf[col][6:0], cmd.glyph_row};
   assign rd_addr   = (state == chroni_pkg::FT_FONT) ? font_addr : addr;
   assign cmd.busy  = (state != chroni_pkg::FT_IDLE);

   always_ff @(posedge sys_clk) begin
      glyph.valid <= 1'b0;
      if (!reset_n || frame_start) begin
         state <= chroni_pkg::FT_IDLE;
      end else begin
         case (state)
            chroni_pkg::FT_IDLE: begin
               if (cmd.start) begin
                  col   <= '0;
                  phase <= 1'b0;
                  addr  <= cmd.char_addr;
                  state <= cmd.blank ? chroni_pkg::FT_SEND : chroni_pkg::FT_CHAR;
               end
            end
            chroni_pkg::FT_CHAR: begin
               phase <= !phase;
               if (phase) begin
                  char_buf[col] <= rd_data;
                  addr          <= addr + 1'b1;
                  col           <= col + 1'b1;
                  if (col == chroni_pkg::col_t'(chroni_pkg::TEXT_COLS - 1)) begin
                     addr  <= cmd.attr_addr;
                     state <= chroni_pkg::FT_ATTR;
                  end
               end
            end
            chroni_pkg::FT_ATTR: begin
               phase <= !phase;
               if (phase) begin
                  attr_buf[col] <= rd_data;
                  addr          <= addr + 1'b1;
                  col           <= col + 1'b1;   // wraps back to column 0
                  if (col == chroni_pkg::col_t'(chroni_pkg::TEXT_COLS - 1))
                     state <= chroni_pkg::FT_FONT;
               end
            end
            chroni_pkg::FT_FONT: begin
               phase <= !phase;
               if (phase) begin
                  glyph.font <= rd_data;
                  state      <= chroni_pkg::FT_SEND;
               end
            end
            chroni_pkg::FT_SEND: begin
               if (ready) begin
                  glyph.valid <= 1'b1;
                  glyph.attr  <= attr_buf[col];
                  glyph.col   <= col;
                  glyph.blank <= cmd.blank;
                  glyph.last  <= (col == chroni_pkg::col_t'(chroni_pkg::TEXT_COLS - 1));
                  col         <= col + 1'b1;
                  if (col == chroni_pkg::col_t'(chroni_pkg::TEXT_COLS - 1))
                     state <= chroni_pkg::FT_DRAIN;
                  else if (!cmd.blank)
                     state <= chroni_pkg::FT_FONT;
               end
            end
            chroni_pkg::FT_DRAIN: if (ready) state <= chroni_pkg::FT_IDLE;   // last glyph out
            default: state <= chroni_pkg::FT_IDLE;
         endcase
      end
   end

endmodule

/* hw/pixel_emit.sv */
`timescale 1ns/100ps

module pixel_emit (
   input  logic                 sys_clk,
   input  logic                 reset_n,
   input  logic                 frame_start,
   glyph_if.slave               glyph,
   output logic                 pix_valid,
   output chroni_pkg::pix_idx_t pix_index,
   output chroni_pkg::color_t   pix_color,
   output logic                 line_done
);

   chroni_pkg::byte_t shift_q;
   chroni_pkg::byte_t attr_q;
   chroni_pkg::col_t  col_q;
   logic              blank_q;
   logic              last_q;
   logic [3:0]        bits_left;
   logic [2:0]        bit_pos;
   logic              done_pend;
   logic              load;

   assign glyph.busy = (bits_left != 4'd0);
   assign load       = glyph.valid && (bits_left == 4'd0);
   assign bit_pos    = 3'(4'd8 - bits_left);

   always_ff @(posedge sys_clk) begin
      if (!reset_n || frame_start) begin
         bits_left <= '0;
         pix_valid <= 1'b0;
         done_pend <= 1'b0;
         line_done <= 1'b0;
      end else begin
         pix_valid <= (bits_left != 4'd0);
         done_pend <= last_q && (bits_left == 4'd1);   // pixel 127 goes out now
         line_done <= done_pend;
         if (load)
            bits_left <= 4'd8;
         else if (bits_left != 4'd0)
            bits_left <= bits_left - 1'b1;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (load) begin
         shift_q <= glyph.font;
         attr_q  <= glyph.attr;
         col_q   <= glyph.col;
         blank_q <= glyph.blank;
         last_q  <= glyph.last;
      end else if (bits_left != 4'd0) begin
         shift_q   <= shift_q << 1;   // msb is the leftmost pixel
         pix_index <= {col_q, bit_pos};
         // fg in the low nibble, bg in the high nibble
         pix_color <= blank_q ? '0 : (shift_q[7] ? attr_q[3:0] : attr_q[7:4]);
      end
   end

endmodule

/* hw/chroni_top.sv */
`timescale 1ns/100ps

module chroni_top (
   input  logic                 sys_clk,
   input  logic                 reset_n,
   input  logic [15:0]          cpu_addr,
   input  chroni_pkg::byte_t    cpu_wr_data,
   input  logic                 cpu_wr_en,
   output chroni_pkg::byte_t    cpu_rd_data,
   input  logic                 frame_start,
   input  logic                 line_start,
   output logic                 pix_valid,
   output chroni_pkg::pix_idx_t pix_index,
   output chroni_pkg::color_t   pix_color,
   output logic                 line_done
);

   chroni_pkg::vram_addr_t dl_base;
   chroni_pkg::byte_t      charset;
   logic                   vram_wr_en;
   chroni_pkg::vram_addr_t vram_wr_addr;
   chroni_pkg::byte_t      vram_wr_data;
   chroni_pkg::vram_addr_t dl_rd_addr;
   chroni_pkg::byte_t      dl_rd_data;
   chroni_pkg::vram_addr_t fetch_rd_addr;
   chroni_pkg::byte_t      fetch_rd_data;

   line_cmd_if line_cmd ();
   glyph_if    glyph ();

   cpu_regs i_cpu_regs (
      .sys_clk, .reset_n, .cpu_addr, .cpu_wr_data, .cpu_wr_en, .cpu_rd_data,
      .dl_base, .charset, .vram_wr_en, .vram_wr_addr, .vram_wr_data
   );

   video_ram i_video_ram (
      .sys_clk,
      .wr_en         (vram_wr_en),
      .wr_addr       (vram_wr_addr),
      .wr_data       (vram_wr_data),
      .dl_rd_addr, .fetch_rd_addr, .dl_rd_data, .fetch_rd_data
   );

   dl_decode i_dl_decode (
      .sys_clk, .reset_n, .frame_start, .line_start, .dl_base, .charset,
      .rd_addr (dl_rd_addr),
      .rd_data (dl_rd_data),
      .cmd     (line_cmd)
   );

   text_fetch i_text_fetch (
      .sys_clk, .reset_n, .frame_start,
      .rd_addr (fetch_rd_addr),
      .rd_data (fetch_rd_data),
      .cmd     (line_cmd),
      .glyph   (glyph)
   );

   pixel_emit i_pixel_emit (
      .sys_clk, .reset_n, .frame_start,
      .glyph (glyph),
      .pix_valid, .pix_index, .pix_color, .line_done
   );

endmodule

/* dv/tb_chroni.sv */
`timescale 1ns/100ps

module tb_chroni;

   logic                 sys_clk;
   logic                 reset_n;
   logic [15:0]          cpu_addr;
   chroni_pkg::byte_t    cpu_wr_data;
   logic                 cpu_wr_en;
   chroni_pkg::byte_t    cpu_rd_data;
   logic                 frame_start;
   logic                 line_start;
   logic                 pix_valid;
   chroni_pkg::pix_idx_t pix_index;
   chroni_pkg::color_t   pix_color;
   logic                 line_done;

   chroni_pkg::byte_t vram_model [4096];   // copy of everything the testbench wrote
   logic [11:0]       vaddr_model;
   logic [31:0]       rng;
   int                error_count;
   int                check_count;

   chroni_top i_dut (
      .sys_clk, .reset_n, .cpu_addr, .cpu_wr_data, .cpu_wr_en, .cpu_rd_data,
      .frame_start, .line_start, .pix_valid, .pix_index, .pix_color, .line_done
   );

   initial begin
      sys_clk = 1'b0;
      forever #5 sys_clk = ~sys_clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // font bit 7 is the leftmost pixel, a set bit takes the low attribute nibble
   function automatic chroni_pkg::color_t expected_color(input logic [11:0] char_base,
         input logic [11:0] attr_base, input int line, input logic [1:0] cs, input int pix);
      logic [11:0]       row_off;
      logic [11:0]       font_addr;
      chroni_pkg::byte_t code;
      chroni_pkg::byte_t attr;
      chroni_pkg::byte_t font;
      int                bit_n;
      row_off   = 12'(16 * (line / 8) + pix / 8);
      bit_n     = 7 - (pix % 8);
      code      = vram_model[char_base + row_off];
      attr      = vram_model[attr_base + row_off];
      font_addr = 12'(cs * 1024 + code[6:0] * 8 + line % 8);
      font      = vram_model[font_addr];
      return font[bit_n] ? attr[3:0] : attr[7:4];
   endfunction

   task automatic reg_write(input logic [6:0] offset, input chroni_pkg::byte_t data);
      @(posedge sys_clk);
      cpu_addr    <= {chroni_pkg::REG_BASE, offset};
      cpu_wr_data <= data;
      cpu_wr_en   <= 1'b1;
      @(posedge sys_clk);
      cpu_wr_en <= 1'b0;   // next write needs a fresh rising edge
   endtask

   task automatic reg_check(input logic [6:0] offset, input chroni_pkg::byte_t expected,
         input string name);
      @(posedge sys_clk);
      cpu_addr <= {chroni_pkg::REG_BASE, offset};
      @(posedge sys_clk);
      @(negedge sys_clk);
      check_count++;
      if (cpu_rd_data !== expected) begin
         $display("MISMATCH cpu_rd_data %s: got %h expected %h", name, cpu_rd_data, expected);
         error_count++;
      end
   endtask

   task automatic set_vaddr(input logic [11:0] addr);
      reg_write(chroni_pkg::REG_VADDR_LO, addr[7:0]);
      reg_write(chroni_pkg::REG_VADDR_HI, {4'h0, addr[11:8]});
      vaddr_model = addr;
   endtask

   task automatic vram_put(input chroni_pkg::byte_t data);
      reg_write(chroni_pkg::REG_VDATA, data);
      vram_model[vaddr_model] = data;
      vaddr_model = vaddr_model + 12'd1;
   endtask

   task automatic vram_fill_random(input logic [11:0] addr, input int count);
      set_vaddr(addr);
      repeat (count) begin
         rng = xorshift(rng);
         vram_put(rng[7:0]);
      end
   endtask

   task automatic put_text_entry(input chroni_pkg::byte_t lines, input logic [11:0] char_base,
         input logic [11:0] attr_base);
      vram_put(8'h01);
      vram_put(lines);
      vram_put(char_base[7:0]);
      vram_put({4'h0, char_base[11:8]});
      vram_put(attr_base[7:0]);
      vram_put({4'h0, attr_base[11:8]});
   endtask

   task automatic set_dl_base(input logic [11:0] addr);
      reg_write(chroni_pkg::REG_DL_LO, addr[7:0]);
      reg_write(chroni_pkg::REG_DL_HI, {4'h0, addr[11:8]});
   endtask

   task automatic pulse_frame_start();
      @(posedge sys_clk);
      frame_start <= 1'b1;
      @(posedge sys_clk);
      frame_start <= 1'b0;
   endtask

   task automatic pulse_line_start();
      @(posedge sys_clk);
      line_start <= 1'b1;
      @(posedge sys_clk);
      line_start <= 1'b0;
   endtask

   // start one line and compare every pixel until line_done
   task automatic check_line(input logic blank, input logic [11:0] char_base,
         input logic [11:0] attr_base, input int line, input logic [1:0] cs);
      int                 pixels;
      int                 cycles;
      int                 last_pix_cycle;
      logic               done;
      chroni_pkg::color_t exp_color;
      pixels         = 0;
      cycles         = 0;
      last_pix_cycle = 0;
      done           = 1'b0;
      pulse_line_start();
      while (!done && cycles < 2000) begin
         @(negedge sys_clk);
         cycles++;
         if (pix_valid) begin
            exp_color = blank ? 4'h0 : expected_color(char_base, attr_base, line, cs, pixels);
            check_count++;
            if (pix_index !== chroni_pkg::pix_idx_t'(pixels)) begin
               $display("MISMATCH pix_index: got %h expected %h", pix_index, pixels[6:0]);
               error_count++;
            end
            if (pix_color !== exp_color) begin
               $display("MISMATCH pix_color: got %h expected %h (line %0d pixel %0d)",
                        pix_color, exp_color, line, pixels);
               error_count++;
            end
            pixels++;
            last_pix_cycle = cycles;
         end
         if (line_done)
            done = 1'b1;
      end
      check_count++;
      if (!done) begin
         $display("line %0d timed out waiting for line_done", line);
         error_count++;
      end else begin
         if (pixels != chroni_pkg::LINE_PIXELS) begin
            $display("MISMATCH pixel count: got %h expected %h", pixels,
                     chroni_pkg::LINE_PIXELS);
            error_count++;
         end
         // line_done comes on the cycle right after pixel 127
         if (cycles != last_pix_cycle + 1) begin
            $display("line_done on line %0d did not follow the last pixel by one cycle", line);
            error_count++;
         end
         @(negedge sys_clk);
         if (line_done) begin
            $display("line_done stayed high for more than one cycle on line %0d", line);
            error_count++;
         end
      end
   endtask

   task automatic expect_no_output();
      int cycles;
      cycles = 0;
      pulse_line_start();
      check_count++;
      while (cycles < 400) begin
         @(negedge sys_clk);
         cycles++;
         if (pix_valid || line_done) begin
            $display("pixels or line_done appeared after the end entry");
            error_count++;
            cycles = 400;
         end
      end
   endtask

   task automatic test_registers();
      reg_write(chroni_pkg::REG_DL_LO, 8'h34);
      reg_write(chroni_pkg::REG_DL_HI, 8'hfa);
      reg_write(chroni_pkg::REG_CHARSET, 8'ha5);
      set_vaddr(12'hffe);
      reg_check(chroni_pkg::REG_DL_LO, 8'h34, "dl_lo");
      reg_check(chroni_pkg::REG_DL_HI, 8'h0a, "dl_hi");   // upper nibble reads as zero
      reg_check(chroni_pkg::REG_CHARSET, 8'ha5, "charset");
      reg_check(chroni_pkg::REG_VADDR_LO, 8'hfe, "vaddr_lo");
      reg_check(chroni_pkg::REG_VADDR_HI, 8'h0f, "vaddr_hi");
      repeat (3) begin
         rng = xorshift(rng);
         vram_put(rng[7:0]);
      end
      // three writes from 0xffe wrap around to 0x001
      reg_check(chroni_pkg::REG_VADDR_LO, vaddr_model[7:0], "vaddr_lo");
      reg_check(chroni_pkg::REG_VADDR_HI, {4'h0, vaddr_model[11:8]}, "vaddr_hi");
   endtask

   task automatic load_scene();
      vram_fill_random(12'h000, 2048);   // fonts for charset 0 and 1
      vram_fill_random(12'h800, 32);     // two rows of characters
      vram_fill_random(12'h840, 32);     // two rows of attributes
      set_vaddr(12'hc00);
      put_text_entry(8'd1, 12'h800, 12'h840);
      vram_put(8'h0f);
      set_vaddr(12'hc10);
      put_text_entry(8'd12, 12'h800, 12'h840);
      vram_put(8'h0f);
      set_vaddr(12'hc20);
      vram_put(8'h50);   // blank entry with junk in the high nibble
      vram_put(8'd2);
      put_text_entry(8'd1, 12'h800, 12'h840);
      vram_put(8'hff);
   endtask

   task automatic test_one_line();
      set_dl_base(12'hc00);
      reg_write(chroni_pkg::REG_CHARSET, 8'h00);
      pulse_frame_start();
      check_line(1'b0, 12'h800, 12'h840, 0, 2'd0);
   endtask

   task automatic test_row_advance();
      int k;
      set_dl_base(12'hc10);
      pulse_frame_start();
      for (k = 0; k < 12; k++)
         check_line(1'b0, 12'h800, 12'h840, k, 2'd0);
   endtask

   task automatic test_blank_entries();
      set_dl_base(12'hc20);
      pulse_frame_start();
      check_line(1'b1, 12'h800, 12'h840, 0, 2'd0);
      check_line(1'b1, 12'h800, 12'h840, 1, 2'd0);
      check_line(1'b0, 12'h800, 12'h840, 0, 2'd0);
   endtask

   task automatic test_end_restart();
      set_dl_base(12'hc00);
      reg_write(chroni_pkg::REG_CHARSET, 8'h00);
      pulse_frame_start();
      check_line(1'b0, 12'h800, 12'h840, 0, 2'd0);
      expect_no_output();
      expect_no_output();
      reg_write(chroni_pkg::REG_CHARSET, 8'h01);
      pulse_frame_start();
      check_line(1'b0, 12'h800, 12'h840, 0, 2'd1);
   endtask

   initial begin
      reset_n     = 1'b0;
      cpu_addr    = '0;
      cpu_wr_data = '0;
      cpu_wr_en   = 1'b0;
      frame_start = 1'b0;
      line_start  = 1'b0;
      vaddr_model = '0;
      rng         = 32'hfe3f;
      error_count = 0;
      check_count = 0;
      repeat (2) @(posedge sys_clk);
      reset_n <= 1'b1;
      @(negedge sys_clk);
      check_count++;
      if (pix_valid !== 1'b0 || line_done !== 1'b0) begin
         $display("pix_valid or line_done not low after reset");
         error_count++;
      end
      test_registers();
      load_scene();
      test_one_line();
      test_row_advance();
      test_blank_entries();
      test_end_restart();
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* sim.f */
hw/chroni_pkg.sv
hw/chroni_ifs.sv
hw/cpu_regs.sv
hw/video_ram.sv
hw/dl_decode.sv
hw/text_fetch.sv
hw/pixel_emit.sv
hw/chroni_top.sv
dv/tb_chroni.sv

/* Makefile */
SIM      = verilator
TOP      = tb_chroni
FILELIST = sim.f
FLAGS    = --binary --timing -Wno-fatal
LINT     = --lint-only --timing -Wall
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then exit 1; fi
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
